// ==== all.f ====
+incdir+hw
hw/ldpc_pkg.sv
hw/ldpc_ibuf.sv
hw/ldpc_ctrl.sv
hw/ldpc_edge_mem.sv
hw/ldpc_cnode.sv
hw/ldpc_vnode.sv
hw/ldpc_sink.sv
hw/ldpc_dec_engine.sv
verif/ldpc_dec_sva.sv
verif/ldpc_dec_checker.sv
verif/tb_ldpc_dec.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and judge the run from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ldpc_dec -f all.f -Mdir obj_dir -o sim_tb > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL: no result line"; exit 1; }
echo "PASS"
exit 0

// ==== verif/tb_ldpc_dec.sv ====
// directed and random frames; the run is bounded by a watchdog budget grown per frame
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_defs.svh"

module tb_ldpc_dec;

  import ldpc_pkg::*;

  logic                     iclk;
  logic                     ireset;
  logic                     isop;
  logic                     ieop;
  logic                     ival;
  llr_beat_t                illr;
  logic [`NITER_W-1:0]      initer;
  logic [`TAG_W-1:0]        itag;
  logic                     irdy;
  logic                     ordy;
  logic                     obusy;
  logic                     osop;
  logic                     oval;
  logic                     oeop;
  logic [`ADDR_W-1:0]       oaddr;
  logic [`TAG_W-1:0]        otag;
  logic [`LLR_BY_CYCLE-1:0] odat;
  logic                     odecfail;
  logic [`ERR_W-1:0]        oerr;
  int                       chk_errors;
  int                       frames_done;
  logic [`LDPC_N-1:0]       last_bits;
  logic [`ERR_W-1:0]        last_errs;
  logic                     last_fail;
  logic [31:0]              rng;
  int                       tb_errors;
  int                       sent;
  int                       budget;
  int                       cycles;
  int                       mark;
  logic [39:0]              llrs;
  logic [31:0]              r;

  ldpc_dec_engine i_dut (.*);

  ldpc_dec_checker i_chk (.*, .errors(chk_errors));

  initial iclk = 1'b0;
  always #10 iclk = ~iclk;

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // one frame on falling edges with optional idle gaps
  task automatic send_frame(input logic [39:0] l, input int niter, input int tag, input bit gaps);
    budget += niter * 12 + 40;
    for (int b = 0; b < 4; b++) begin
      @(negedge iclk);
      ival = 1'b0;
      if (gaps && next_rand() % 3 == 0) @(negedge iclk);
      while (!ordy) @(negedge iclk);
      ival   = 1'b1;
      isop   = (b == 0);
      ieop   = (b == 3);
      illr   = l[b*10 +: 10];
      initer = niter[3:0];
      itag   = tag[3:0];
    end
    @(negedge iclk);
    ival = 1'b0;
    isop = 1'b0;
    ieop = 1'b0;
    sent++;
  endtask

  task automatic wait_frames();
    while (frames_done < sent) @(posedge iclk);
    @(negedge iclk);
  endtask

  task automatic expect_last(input logic [7:0] bits, input int errs, input string what);
    if (last_bits != bits || last_errs != errs[3:0] || last_fail) begin
      $display("mismatch at %0t: %s gave bits %b errs %0d fail %0d", $time, what,
               last_bits, last_errs, last_fail);
      tb_errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s done, %0d errors", name, chk_errors + tb_errors - mark);
    mark = chk_errors + tb_errors;
  endtask

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  always @(posedge iclk) begin
    cycles++;
    if (cycles > budget) begin
      $display("timeout: frames still pending after %0d cycles", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    rng = 32'h7852;
    tb_errors = 0;
    sent = 0;
    budget = 200;
    cycles = 0;
    mark = 0;
    ireset = 1'b1;
    {isop, ieop, ival} = 3'b000;
    illr = '0;
    initer = 4'd1;
    itag = '0;
    irdy = 1'b1;
    repeat (2) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;

    // strong codewords where +12 means bit 0
    send_frame({8{5'sd12}}, 4, 1, 0);
    wait_frames();
    expect_last(8'h00, 0, "all-zero codeword");
    send_frame({{4{5'sd12}}, {4{-5'sd12}}}, 4, 2, 0);
    wait_frames();
    expect_last(8'h0F, 0, "codeword 11110000");
    end_test("strong codewords");

    // bit 0 weak and flipped
    send_frame({{7{5'sd8}}, -5'sd2}, 3, 3, 0);
    wait_frames();
    expect_last(8'h00, 1, "weak flip");
    end_test("weak flip");

    for (int f = 0; f < 200; f++) begin
      for (int b = 0; b < 8; b++) begin
        r = next_rand();
        llrs[b*5 +: 5] = r[4:0];
      end
      r = next_rand();
      send_frame(llrs, 1 + r % 15, r[7:4], 1);
    end
    wait_frames();
    end_test("random frames");

    // -16 inputs mixed in
    for (int f = 0; f < 8; f++) begin
      for (int b = 0; b < 8; b++) begin
        r = next_rand();
        llrs[b*5 +: 5] = (r[1:0] == 2'b00) ? 5'b10000 : r[6:2];
      end
      send_frame(llrs, 1 + next_rand() % 15, f, 0);
    end
    wait_frames();
    end_test("saturated inputs");

    // both banks filled while decode is held back
    irdy = 1'b0;
    send_frame({8{5'sd7}}, 2, 10, 0);
    send_frame({{4{-5'sd7}}, {4{5'sd7}}}, 5, 11, 0);
    budget += 60;
    for (int c = 0; c < 40; c++) begin
      @(negedge iclk);
      if (ordy) begin
        $display("mismatch at %0t: ordy high with both banks holding frames", $time);
        tb_errors++;
      end
      if (oval) begin
        $display("output beat at %0t while irdy was low", $time);
        tb_errors++;
      end
    end
    irdy = 1'b1;
    wait_frames();
    end_test("held decode");

    $display("frames sent %0d, checked %0d, errors %0d", sent, frames_done,
             chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/ldpc_dec_checker.sv ====
// watches the DUT ports; expects whole 4-beat frames in and frames out in arrival order
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_defs.svh"

module ldpc_dec_checker (
  input  wire                       iclk,
  input  wire                       ireset,
  input  wire                       isop,
  input  wire                       ieop,
  input  wire                       ival,
  input  ldpc_pkg::llr_beat_t       illr,
  input  wire [`NITER_W-1:0]        initer,
  input  wire [`TAG_W-1:0]          itag,
  input  wire                       obusy,
  input  wire                       osop,
  input  wire                       oval,
  input  wire                       oeop,
  input  wire [`ADDR_W-1:0]         oaddr,
  input  wire [`TAG_W-1:0]          otag,
  input  wire [`LLR_BY_CYCLE-1:0]   odat,
  input  wire                       odecfail,
  input  wire [`ERR_W-1:0]          oerr,
  output int                        errors,
  output int                        frames_done,
  output logic [`LDPC_N-1:0]        last_bits,
  output logic [`ERR_W-1:0]         last_errs,
  output logic                      last_fail
);

  // expected entry holds tag, error count, fail flag and 8 decisions
  logic [16:0]        exp_q [$];
  logic [16:0]        exp;
  logic [39:0]        llrs;
  logic [3:0]         cur_niter;
  logic [3:0]         cur_tag;
  int                 in_cnt;
  int                 out_cnt;
  logic [`LDPC_N-1:0] obs_bits;
  logic               in_frame;

  // bit on edge e where rows 0 and 1 are contiguous and rows 2 and 3 take even and odd bits
  function automatic int edge_bit(input int e);
    return (e < 8) ? e : 2 * (e % 4) + (e / 4 - 2);
  endfunction

  // normalized min-sum with flooding and +-15 saturation
  function automatic logic [12:0] ref_decode(input logic [39:0] l, input int niter);
    int ch [8];
    int tot [8];
    int v2c [16];
    int c2v [16];
    int m;
    int s;
    int r;
    int a;
    int errs;
    logic [7:0] bits;
    logic fail;
    for (int b = 0; b < 8; b++) begin
      ch[b] = $signed(l[b*5 +: 5]);
      if (ch[b] < -15) ch[b] = -15;
    end
    for (int e = 0; e < 16; e++) begin
      v2c[e] = ch[edge_bit(e)];
      c2v[e] = 0;
    end
    for (int it = 0; it < niter; it++) begin
      // check update leaves the own edge out
      for (int e = 0; e < 16; e++) begin
        m = 15;
        s = 0;
        for (int q = 0; q < 4; q++) begin
          if ((e / 4) * 4 + q != e) begin
            a = v2c[(e / 4) * 4 + q];
            if (a < 0) s = s ^ 1;
            if (a < 0) a = -a;
            if (a < m) m = a;
          end
        end
        r = (3 * m) / 4;
        c2v[e] = s ? -r : r;
      end
      // bit update
      for (int b = 0; b < 8; b++) tot[b] = ch[b];
      for (int e = 0; e < 16; e++) tot[edge_bit(e)] += c2v[e];
      for (int e = 0; e < 16; e++) begin
        a = tot[edge_bit(e)] - c2v[e];
        v2c[e] = (a > 15) ? 15 : (a < -15) ? -15 : a;
      end
    end
    errs = 0;
    for (int b = 0; b < 8; b++) begin
      bits[b] = (tot[b] < 0);
      if (bits[b] != (ch[b] < 0)) errs++;
    end
    fail = 1'b0;
    for (int e = 0; e < 16; e++) begin
      if (e % 4 == 0) s = 0;
      s = s ^ int'(bits[edge_bit(e)]);
      if (e % 4 == 3 && s != 0) fail = 1'b1;
    end
    return {4'(errs), fail, bits};
  endfunction

  task automatic report(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    errors++;
  endtask

  initial begin
    errors      = 0;
    frames_done = 0;
    in_cnt      = 0;
    out_cnt     = 0;
    in_frame    = 1'b0;
  end

  // --------------------------------------------------
  // capture inputs and compare outputs
  // --------------------------------------------------
  always @(posedge iclk) begin
    if (!ireset) begin
      // obusy lags the accepted sop and eop by one cycle
      if (obusy != in_frame)
        report($sformatf("obusy %0d, expected %0d", obusy, in_frame));
      if (ival) begin
        if (isop) begin
          in_cnt    = 0;
          in_frame  = 1'b1;
          cur_niter = initer;
          cur_tag   = itag;
        end
        llrs[in_cnt*10 +: 10] = illr;
        in_cnt++;
        if (ieop) begin
          exp_q.push_back({cur_tag, ref_decode(llrs, int'(cur_niter))});
          in_frame = 1'b0;
        end
      end
      if (oval) begin
        if (exp_q.size() == 0) begin
          $display("output beat at %0t with no frame pending", $time);
          errors++;
        end else begin
          exp = exp_q[0];
          if (osop) out_cnt = 0;
          if (oaddr != out_cnt[1:0] || osop != (out_cnt == 0))
            report($sformatf("beat order addr %0d sop %0d, expected %0d", oaddr, osop, out_cnt));
          if (odat != exp[out_cnt*2 +: 2])
            report($sformatf("odat %b, expected %b", odat, exp[out_cnt*2 +: 2]));
          if (otag != exp[16:13])
            report($sformatf("otag %h, expected %h", otag, exp[16:13]));
          obs_bits[out_cnt*2 +: 2] = odat;
          out_cnt++;
          if (oeop) begin
            if (odecfail != exp[8] || oerr != exp[12:9])
              report($sformatf("fail %0d errs %0d, expected %0d %0d",
                               odecfail, oerr, exp[8], exp[12:9]));
            if (out_cnt != 4) report("frame did not have 4 beats");
            last_bits = obs_bits;
            last_errs = oerr;
            last_fail = odecfail;
            void'(exp_q.pop_front());
            frames_done++;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/ldpc_dec_sva.sv ====
// port-level protocol checks only; bound into every ldpc_dec_engine instance
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_defs.svh"

module ldpc_dec_sva (
  input wire                iclk,
  input wire                ireset,
  input wire                ival,
  input wire                isop,
  input wire [`NITER_W-1:0] initer,
  input wire                ordy,
  input wire                osop,
  input wire                oval,
  input wire                oeop
);

  // --------------------------------------------------
  // input side
  // --------------------------------------------------
  // beats only into a free bank
  a_no_val_without_rdy : assert property (@(posedge iclk) disable iff (ireset)
    ival |-> ordy)
    else $error("input beat accepted while ordy low");

  // zero iterations is not a legal frame
  a_niter_nonzero : assert property (@(posedge iclk) disable iff (ireset)
    (ival && isop) |-> (initer != '0))
    else $error("frame started with zero iteration count");

  // --------------------------------------------------
  // output side
  // --------------------------------------------------
  // eop closes a run of 4 beats opened by sop
  a_eop_framing : assert property (@(posedge iclk) disable iff (ireset)
    oeop |-> (oval && $past(oval, 1) && $past(oval, 2) && $past(oval, 3) && $past(osop, 3)))
    else $error("oeop without three oval beats after osop");

  // quiet outputs while in reset
  a_reset_quiet : assert property (@(posedge iclk)
    ireset |-> (!oval && !osop && !oeop))
    else $error("output strobes active during reset");

endmodule

bind ldpc_dec_engine ldpc_dec_sva i_sva (.*);

`default_nettype wire

// ==== hw/ldpc_dec_engine.sv ====
// fixed 8-bit code; decoding starts only with irdy high and never pauses once started
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_defs.svh"

module ldpc_dec_engine (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     isop,
  input  logic                     ieop,
  input  logic                     ival,
  input  ldpc_pkg::llr_beat_t      illr,
  input  logic [`NITER_W-1:0]      initer,
  input  logic [`TAG_W-1:0]        itag,
  input  logic                     irdy,
  output logic                     ordy,
  output logic                     obusy,
  output logic                     osop,
  output logic                     oval,
  output logic                     oeop,
  output logic [`ADDR_W-1:0]       oaddr,
  output logic [`TAG_W-1:0]        otag,
  output logic [`LLR_BY_CYCLE-1:0] odat,
  output logic                     odecfail,
  output logic [`ERR_W-1:0]        oerr
);

  import ldpc_pkg::*;

  // buffer <-> sequencer
  logic                bank_full;
  logic                bank_release;
  hdr_t                hdr;
  pass_cmd_t           cmd;
  llr_beat_t           rd_llr;
  // message store <-> node units
  llr_t [`ROW_DEG-1:0] v2c_rd;
  llr_t [`ROW_DEG-1:0] c2v_rd;
  llr_t [`ROW_DEG-1:0] v2c_wr;
  llr_t [`ROW_DEG-1:0] c2v_wr;
  logic                v2c_we;
  logic                c2v_we;
  bit_beat_t           bit_beat;

  ldpc_ibuf ibuf (
    .iclk(iclk), .ireset(ireset),
    .isop(isop), .ieop(ieop), .ival(ival), .illr(illr), .initer(initer), .itag(itag),
    .cmd(cmd), .bank_release(bank_release),
    .ordy(ordy), .obusy(obusy), .bank_full(bank_full), .rd_llr(rd_llr), .hdr(hdr)
  );

  ldpc_ctrl ctrl (
    .iclk(iclk), .ireset(ireset),
    .bank_full(bank_full), .irdy(irdy), .hdr(hdr),
    .cmd(cmd), .bank_release(bank_release)
  );

  ldpc_edge_mem edge_mem (
    .iclk(iclk), .ireset(ireset), .cmd(cmd),
    .v2c_rd(v2c_rd), .c2v_rd(c2v_rd),
    .v2c_we(v2c_we), .c2v_we(c2v_we), .v2c_wr(v2c_wr), .c2v_wr(c2v_wr)
  );

  ldpc_cnode cnode (
    .iclk(iclk), .ireset(ireset), .cmd(cmd),
    .v2c(v2c_rd), .c2v_we(c2v_we), .c2v(c2v_wr)
  );

  ldpc_vnode vnode (
    .iclk(iclk), .ireset(ireset), .cmd(cmd), .llr(rd_llr),
    .c2v(c2v_rd), .v2c_we(v2c_we), .v2c(v2c_wr), .bit_beat(bit_beat)
  );

  ldpc_sink sink (
    .iclk(iclk), .ireset(ireset), .bit_beat(bit_beat), .hdr(hdr),
    .osop(osop), .oval(oval), .oeop(oeop), .oaddr(oaddr), .otag(otag), .odat(odat),
    .odecfail(odecfail), .oerr(oerr)
  );

endmodule

`default_nettype wire

// ==== hw/ldpc_sink.sv ====
// no output back-pressure; odecfail and oerr are meaningful only in the oeop cycle
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_defs.svh"

module ldpc_sink (
  input  logic                     iclk,
  input  logic                     ireset,
  input  ldpc_pkg::bit_beat_t      bit_beat,
  input  ldpc_pkg::hdr_t           hdr,
  output logic                     osop,
  output logic                     oval,
  output logic                     oeop,
  output logic [`ADDR_W-1:0]       oaddr,
  output logic [`TAG_W-1:0]        otag,
  output logic [`LLR_BY_CYCLE-1:0] odat,
  output logic                     odecfail,
  output logic [`ERR_W-1:0]        oerr
);

  localparam logic [`LDPC_EDGES*`BIT_IDX_W-1:0] EDGE_BIT = `CHECK_TABLE;

  logic [`LDPC_N-1:0] dec_q;
  logic [`LDPC_N-1:0] dec_now;
  logic [`LDPC_M-1:0] syn;
  logic [`ERR_W-1:0]  beat_errs;

  always_comb begin
    // current beat merged over the collected decisions
    dec_now = dec_q;
    dec_now[bit_beat.addr*`LLR_BY_CYCLE +: `LLR_BY_CYCLE] = bit_beat.bits;
    // parity per check over the table
    syn = '0;
    for (int e = 0; e < `LDPC_EDGES; e++) begin
      syn[e / `ROW_DEG] = syn[e / `ROW_DEG] ^ dec_now[EDGE_BIT[e*`BIT_IDX_W +: `BIT_IDX_W]];
    end
    beat_errs = '0;
    for (int j = 0; j < `LLR_BY_CYCLE; j++) begin
      beat_errs = beat_errs + `ERR_W'(bit_beat.errs[j]);
    end
  end

  // --------------------------------------------------
  // strobes and status
  // --------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      osop     <= 1'b0;
      oval     <= 1'b0;
      oeop     <= 1'b0;
      odecfail <= 1'b0;
      oerr     <= '0;
    end else begin
      osop <= bit_beat.val && bit_beat.sop;
      oval <= bit_beat.val;
      oeop <= bit_beat.val && bit_beat.eop;
      if (bit_beat.val) begin
        // running count, restarted at sop
        oerr     <= (bit_beat.sop ? '0 : oerr) + beat_errs;
        odecfail <= bit_beat.eop && (|syn);
      end
    end
  end

  // beat payload
  always_ff @(posedge iclk) begin
    if (bit_beat.val) begin
      oaddr <= bit_beat.addr;
      odat  <= bit_beat.bits;
      otag  <= hdr.tag;
      dec_q <= dec_now;
    end
  end

endmodule

`default_nettype wire

// ==== hw/ldpc_vnode.sv ====
// two bits per beat, degree 2 per bit; results appear one cycle after the command
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_defs.svh"

module ldpc_vnode (
  input  logic                          iclk,
  input  logic                          ireset,
  input  ldpc_pkg::pass_cmd_t           cmd,
  input  ldpc_pkg::llr_beat_t           llr,
  input  ldpc_pkg::llr_t [`ROW_DEG-1:0] c2v,
  output logic                          v2c_we,
  output ldpc_pkg::llr_t [`ROW_DEG-1:0] v2c,
  output ldpc_pkg::bit_beat_t           bit_beat
);

  import ldpc_pkg::*;

  localparam int VAR_DEG = `LDPC_EDGES / `LDPC_N;
  localparam int SUM_W   = `LLR_W + 2;

  pass_cmd_t                cmd_q;
  llr_t [`ROW_DEG-1:0]      c2v_q;
  logic [`LLR_BY_CYCLE-1:0] dec;
  logic [`LLR_BY_CYCLE-1:0] err;

  function automatic llr_t sat(input logic signed [SUM_W-1:0] x);
    if (x > `LLR_MAX) begin
      return llr_t'(`LLR_MAX);
    end
    if (x < -`LLR_MAX) begin
      return llr_t'(-`LLR_MAX);
    end
    return x[`LLR_W-1:0];
  endfunction

  // align c2v with the 1-cycle buffer read
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cmd_q <= '0;
    end else begin
      cmd_q <= cmd;
    end
  end

  always_ff @(posedge iclk) begin
    c2v_q <= c2v;
  end

  // --------------------------------------------------
  // bit update
  // --------------------------------------------------
  always_comb begin
    llr_t                    ch;
    llr_t                    ca;
    llr_t                    cb;
    logic signed [SUM_W-1:0] tot;
    for (int j = 0; j < `LLR_BY_CYCLE; j++) begin
      ch  = llr[j];
      ca  = c2v_q[VAR_DEG*j];
      cb  = c2v_q[VAR_DEG*j + 1];
      tot = ch + ca + cb;
      // load pass seeds both edges with the channel value
      if (cmd_q.kind == KIND_LOAD) begin
        v2c[VAR_DEG*j]     = ch;
        v2c[VAR_DEG*j + 1] = ch;
      end else begin
        v2c[VAR_DEG*j]     = sat(tot - ca);
        v2c[VAR_DEG*j + 1] = sat(tot - cb);
      end
      dec[j] = (tot < 0);
      // differs from channel hard decision
      err[j] = dec[j] ^ ch[`LLR_W-1];
    end
  end

  assign v2c_we = cmd_q.val && (cmd_q.kind != KIND_CNODE);

  // decisions leave only on the final vnode pass
  always_comb begin
    bit_beat      = '0;
    bit_beat.val  = cmd_q.val && (cmd_q.kind == KIND_VNODE) && cmd_q.last;
    bit_beat.sop  = bit_beat.val && cmd_q.sop;
    bit_beat.eop  = bit_beat.val && cmd_q.eop;
    bit_beat.addr = cmd_q.index;
    bit_beat.bits = dec;
    bit_beat.errs = err;
  end

endmodule

`default_nettype wire

// ==== hw/ldpc_cnode.sv ====
// min-sum with fixed 0.75 scale; input messages must already be within +-15
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_defs.svh"

module ldpc_cnode (
  input  logic                          iclk,
  input  logic                          ireset,
  input  ldpc_pkg::pass_cmd_t           cmd,
  input  ldpc_pkg::llr_t [`ROW_DEG-1:0] v2c,
  output logic                          c2v_we,
  output ldpc_pkg::llr_t [`ROW_DEG-1:0] c2v
);

  import ldpc_pkg::*;

  localparam int MAG_W = `LLR_W - 1;

  logic [MAG_W-1:0]     mag [`ROW_DEG];
  logic [`ROW_DEG-1:0]  sgn;
  llr_t [`ROW_DEG-1:0]  c2v_d;

  always_comb begin
    llr_t             v;
    logic [MAG_W-1:0] mn;
    logic             s;
    logic [MAG_W+1:0] prod;
    llr_t             res;
    // sign and magnitude split
    for (int p = 0; p < `ROW_DEG; p++) begin
      v      = v2c[p];
      sgn[p] = v[`LLR_W-1];
      mag[p] = sgn[p] ? MAG_W'(-v) : MAG_W'(v);
    end
    // extrinsic: leave out the edge being answered
    for (int p = 0; p < `ROW_DEG; p++) begin
      mn = '1;
      s  = 1'b0;
      for (int q = 0; q < `ROW_DEG; q++) begin
        if (q != p) begin
          s = s ^ sgn[q];
          if (mag[q] < mn) begin
            mn = mag[q];
          end
        end
      end
      // 3 * min, then >> 2
      prod     = {2'b00, mn} + {1'b0, mn, 1'b0};
      res      = llr_t'({1'b0, prod[MAG_W+1:2]});
      c2v_d[p] = s ? -res : res;
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      c2v_we <= 1'b0;
    end else begin
      c2v_we <= cmd.val && (cmd.kind == KIND_CNODE);
    end
  end

  always_ff @(posedge iclk) begin
    c2v <= c2v_d;
  end

endmodule

`default_nettype wire

// ==== hw/ldpc_edge_mem.sv ====
// every bit must have degree 2; write ports are addressed by the command of the previous cycle
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_defs.svh"

module ldpc_edge_mem (
  input  logic                                iclk,
  input  logic                                ireset,
  input  ldpc_pkg::pass_cmd_t                 cmd,
  output ldpc_pkg::llr_t [`ROW_DEG-1:0]       v2c_rd,
  output ldpc_pkg::llr_t [`ROW_DEG-1:0]       c2v_rd,
  input  logic                                v2c_we,
  input  logic                                c2v_we,
  input  ldpc_pkg::llr_t [`ROW_DEG-1:0]       v2c_wr,
  input  ldpc_pkg::llr_t [`ROW_DEG-1:0]       c2v_wr
);

  import ldpc_pkg::*;

  localparam int VAR_DEG = `LDPC_EDGES / `LDPC_N;
  localparam int EDGE_W  = $clog2(`LDPC_EDGES);
  localparam int SLOTS   = `LLR_BY_CYCLE * VAR_DEG;
  localparam logic [`LDPC_EDGES*`BIT_IDX_W-1:0] EDGE_BIT = `CHECK_TABLE;

  // edge numbers per bit, in edge order, slot = VAR_DEG * bit + k
  function automatic logic [`LDPC_EDGES*EDGE_W-1:0] vn_edge_map();
    logic [`LDPC_EDGES*EDGE_W-1:0] map;
    int fill [`LDPC_N];
    int b;
    map  = '0;
    fill = '{default: 0};
    for (int e = 0; e < `LDPC_EDGES; e++) begin
      b = int'(EDGE_BIT[e*`BIT_IDX_W +: `BIT_IDX_W]);
      map[(VAR_DEG*b + fill[b])*EDGE_W +: EDGE_W] = EDGE_W'(e);
      fill[b]++;
    end
    return map;
  endfunction

  localparam logic [`LDPC_EDGES*EDGE_W-1:0] VN_EDGE = vn_edge_map();

  llr_t               v2c_mem [`LDPC_EDGES];
  llr_t               c2v_mem [`LDPC_EDGES];
  logic [`ADDR_W-1:0] wr_idx;

  // rows for cnode, beats for vnode
  always_comb begin
    for (int p = 0; p < `ROW_DEG; p++) begin
      v2c_rd[p] = v2c_mem[cmd.index*`ROW_DEG + p];
    end
    for (int s = 0; s < SLOTS; s++) begin
      c2v_rd[s] = c2v_mem[VN_EDGE[(cmd.index*SLOTS + s)*EDGE_W +: EDGE_W]];
    end
  end

  // units answer one cycle after the command
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_idx <= '0;
    end else begin
      wr_idx <= cmd.index;
    end
  end

  always_ff @(posedge iclk) begin
    // fresh frame starts with zero check messages
    if (cmd.val && cmd.kind == KIND_LOAD) begin
      c2v_mem <= '{default: '0};
    end else if (c2v_we) begin
      for (int p = 0; p < `ROW_DEG; p++) begin
        c2v_mem[wr_idx*`ROW_DEG + p] <= c2v_wr[p];
      end
    end
    if (v2c_we) begin
      for (int s = 0; s < SLOTS; s++) begin
        v2c_mem[VN_EDGE[(wr_idx*SLOTS + s)*EDGE_W +: EDGE_W]] <= v2c_wr[s];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/ldpc_ctrl.sv ====
// hdr.niter must be 1..15; irdy is sampled only when a frame is about to start
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_defs.svh"

module ldpc_ctrl (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                bank_full,
  input  logic                irdy,
  input  ldpc_pkg::hdr_t      hdr,
  output ldpc_pkg::pass_cmd_t cmd,
  output logic                bank_release
);

  import ldpc_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOAD,
    S_CNODE,
    S_VNODE,
    S_GAP
  } state_t;

  state_t              state;
  state_t              prev;
  logic [`ADDR_W-1:0]  idx;
  logic                gap_cnt;
  logic [`NITER_W-1:0] iter;
  logic                last_iter;
  logic                pass_end;
  logic                in_pass;

  assign last_iter = (iter == hdr.niter);
  assign pass_end  = (idx == `ADDR_W'(`BEATS - 1));
  assign in_pass   = (state == S_LOAD) || (state == S_CNODE) || (state == S_VNODE);

  // --------------------------------------------------
  // pass sequencer
  // --------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state   <= S_IDLE;
      prev    <= S_IDLE;
      idx     <= '0;
      gap_cnt <= 1'b0;
      iter    <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (bank_full && irdy) begin
            state <= S_LOAD;
            idx   <= '0;
            iter  <= `NITER_W'(1);
          end
        end
        S_LOAD, S_CNODE, S_VNODE: begin
          // index wraps to 0 at the end of the pass
          idx <= idx + 1'b1;
          if (pass_end) begin
            prev    <= state;
            state   <= S_GAP;
            gap_cnt <= 1'b0;
          end
        end
        S_GAP: begin
          // two idle cycles so that the last write lands
          gap_cnt <= 1'b1;
          if (gap_cnt) begin
            case (prev)
              S_LOAD:  state <= S_CNODE;
              S_CNODE: state <= S_VNODE;
              default: begin
                if (last_iter) begin
                  state <= S_IDLE;
                end else begin
                  iter  <= iter + 1'b1;
                  state <= S_CNODE;
                end
              end
            endcase
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // command decoded from the state registers
  always_comb begin
    cmd       = '0;
    cmd.val   = in_pass;
    cmd.kind  = (state == S_CNODE) ? KIND_CNODE :
                (state == S_VNODE) ? KIND_VNODE : KIND_LOAD;
    cmd.index = idx;
    cmd.sop   = in_pass && (idx == '0);
    cmd.eop   = in_pass && pass_end;
    // load is not an iteration
    cmd.last  = in_pass && (state != S_LOAD) && last_iter;
  end

  // second gap cycle after the final vnode pass
  assign bank_release = (state == S_GAP) && gap_cnt && (prev == S_VNODE) && last_iter;

endmodule

`default_nettype wire

// ==== hw/ldpc_ibuf.sv ====
// frames must be exactly 4 beats and arrive only while ordy is high; -16 is stored as -15
`timescale 1ns/1ps
`default_nettype none

`include "ldpc_defs.svh"

module ldpc_ibuf (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                isop,
  input  logic                ieop,
  input  logic                ival,
  input  ldpc_pkg::llr_beat_t illr,
  input  logic [`NITER_W-1:0] initer,
  input  logic [`TAG_W-1:0]   itag,
  input  ldpc_pkg::pass_cmd_t cmd,
  input  logic                bank_release,
  output logic                ordy,
  output logic                obusy,
  output logic                bank_full,
  output ldpc_pkg::llr_beat_t rd_llr,
  output ldpc_pkg::hdr_t      hdr
);

  import ldpc_pkg::*;

  llr_beat_t          mem     [2][`BEATS];
  hdr_t               hdr_mem [2];
  logic [`ADDR_W-1:0] wcnt    [2];
  logic [1:0]         full;
  logic               wr_ptr;
  logic               rd_ptr;
  logic               busy_q;
  logic [`ADDR_W-1:0] waddr;
  llr_beat_t          wdat;

  // clamp the one code outside the symmetric range
  function automatic llr_t sat(input llr_t x);
    if (x < -`LLR_MAX) begin
      return llr_t'(-`LLR_MAX);
    end
    return x;
  endfunction

  // sop restarts the beat count
  always_comb begin
    waddr = isop ? '0 : wcnt[wr_ptr];
    for (int j = 0; j < `LLR_BY_CYCLE; j++) begin
      wdat[j] = sat(illr[j]);
    end
  end

  // --------------------------------------------------
  // bank pointers, counters and full flags
  // --------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wcnt   <= '{default: '0};
      full   <= '0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      if (ival) begin
        wcnt[wr_ptr] <= waddr + 1'b1;
        if (isop) begin
          busy_q <= 1'b1;
        end
        // frame complete, hand bank over to the read side
        if (ieop) begin
          full[wr_ptr] <= 1'b1;
          wr_ptr       <= ~wr_ptr;
          busy_q       <= 1'b0;
        end
      end
      // decode done, bank free again
      if (bank_release) begin
        full[rd_ptr] <= 1'b0;
        rd_ptr       <= ~rd_ptr;
      end
    end
  end

  // payload and header
  always_ff @(posedge iclk) begin
    if (ival) begin
      mem[wr_ptr][waddr] <= wdat;
    end
    if (ival && isop) begin
      hdr_mem[wr_ptr] <= '{niter: initer, tag: itag};
    end
    // load and vnode passes both need channel values
    if (cmd.val && cmd.kind != KIND_CNODE) begin
      rd_llr <= mem[rd_ptr][cmd.index];
    end
  end

  // write bank full only when both banks hold frames
  assign ordy      = ~full[wr_ptr];
  assign obusy     = busy_q;
  assign bank_full = full[rd_ptr];
  assign hdr       = hdr_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== hw/ldpc_pkg.sv ====
// shared types only; needs ldpc_defs.svh on the include path and compiles before the RTL
`default_nettype none

`include "ldpc_defs.svh"

package ldpc_pkg;

  // pass kinds issued by the sequencer
  typedef enum logic [1:0] {
    KIND_LOAD,
    KIND_CNODE,
    KIND_VNODE
  } pass_kind_t;

  // one message, two's complement
  typedef logic signed [`LLR_W-1:0] llr_t;

  // one input beat, element 0 is the lower bit index
  typedef llr_t [`LLR_BY_CYCLE-1:0] llr_beat_t;

  // per-frame header, latched at the first beat
  typedef struct packed {
    logic [`NITER_W-1:0] niter;
    logic [`TAG_W-1:0]   tag;
  } hdr_t;

  // one pass cycle, fanned out to every unit
  typedef struct packed {
    pass_kind_t         kind;
    logic               sop;
    logic               val;
    logic               eop;
    logic [`ADDR_W-1:0] index;
    logic               last;
  } pass_cmd_t;

  // decision beat from vnode to sink
  typedef struct packed {
    logic                     sop;
    logic                     val;
    logic                     eop;
    logic [`ADDR_W-1:0]       addr;
    logic [`LLR_BY_CYCLE-1:0] bits;
    logic [`LLR_BY_CYCLE-1:0] errs;
  } bit_beat_t;

endpackage

`default_nettype wire

// ==== hw/ldpc_defs.svh ====
// fixed 8-bit, 4-check code; the check table and the widths below must change together
`ifndef LDPC_DEFS_SVH
`define LDPC_DEFS_SVH

// code size
`define LDPC_N       8
`define LDPC_M       4
`define LDPC_EDGES   16
`define ROW_DEG      4

// message format, saturated symmetric
`define LLR_W        5
`define LLR_MAX      15

// input and output beat shape
`define LLR_BY_CYCLE 2
`define BEATS        4
`define ADDR_W       2

// frame header and status widths
`define NITER_W      4
`define TAG_W        4
`define ERR_W        4

// --------------------------------------------------
// check to bit table, 3-bit bit indices
// position 0 sits in the low bits, edge = 4 * check + position
// --------------------------------------------------
`define BIT_IDX_W    3
`define CHECK_BITS_0 {3'd3, 3'd2, 3'd1, 3'd0}
`define CHECK_BITS_1 {3'd7, 3'd6, 3'd5, 3'd4}
`define CHECK_BITS_2 {3'd6, 3'd4, 3'd2, 3'd0}
`define CHECK_BITS_3 {3'd7, 3'd5, 3'd3, 3'd1}

// whole table, indexed by edge number
`define CHECK_TABLE  {`CHECK_BITS_3, `CHECK_BITS_2, `CHECK_BITS_1, `CHECK_BITS_0}

`endif
